/* bench/tb_op_fetch.sv */
`timescale 1ns/1ps

module tb_op_fetch import op_fetch_pkg::*; ();
	localparam int n_instr = 300;
	localparam int n_latency = 40; // Register and constant operands only
	localparam int worst_cycles = 40;
	localparam int cycle_limit = n_instr * worst_cycles;
	localparam logic [31:0] seed = 32'hd261e6e4;

	logic clk, reset;
	logic in_valid, in_ready, out_valid, out_ready;
	logic [op_width-1:0] operation, operation_out;
	logic [chan_addr_width-1:0] dest, dest_out;
	logic writes_channel, writes_channel_out;
	logic [data_width-1:0] register_0, register_1, arg_a, arg_b, arg_c;
	operand_src_t src_a, src_b, src_c;
	logic src_a_reg, src_b_reg, src_c_reg, arg_a_needed, arg_b_needed, arg_c_needed;
	logic channel_write_enable;
	logic [chan_addr_width-1:0] channel_write_addr;
	logic [data_width-1:0] channel_write_val;

	// Program-order model and expected results by sequence number
	logic [data_width-1:0] model_ch [n_channels];
	logic [op_width-1:0] exp_op_mem [512];
	logic [chan_addr_width-1:0] exp_dest_mem [512];
	logic exp_wr_mem [512];
	logic [data_width-1:0] exp_a_mem [512], exp_b_mem [512], exp_c_mem [512], wb_val_mem [512];
	int wb_q [$];
	int in_count, out_count, cycles;
	logic [31:0] rs_main, rs_ready;
	logic [chan_addr_width-1:0] prev_dest;
	logic latency_check, ready_random;
	logic prev_reset = 1'b1;
	logic prev_hold;
	logic [2:0] hs_delay;
	logic [result_width-1:0] result_now, prev_result;
	logic [op_width-1:0] exp_op_now;
	logic [chan_addr_width-1:0] exp_dest_now;
	logic exp_wr_now, out_take;
	logic [data_width-1:0] exp_a_now, exp_b_now, exp_c_now;

	op_fetch_stage uut (.*);

	assign out_take = out_valid & out_ready;
	assign result_now = {operation_out, dest_out, writes_channel_out, arg_a, arg_b, arg_c};
	assign exp_op_now = exp_op_mem[out_count];
	assign exp_dest_now = exp_dest_mem[out_count];
	assign exp_wr_now = exp_wr_mem[out_count];
	assign exp_a_now = exp_a_mem[out_count];
	assign exp_b_now = exp_b_mem[out_count];
	assign exp_c_now = exp_c_mem[out_count];

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rs_main = xorshift32(rs_main);
		return rs_main;
	endfunction

	function automatic logic [data_width-1:0] expected_operand(input operand_src_t src,
		input logic use_reg, input logic needed);
		if (!needed)
			return '0;
		if (!use_reg)
			return model_ch[src.channel];
		case (src.code)
			4'd0: return register_0;
			4'd1: return register_1;
			4'd3: return 16'h4000;
			4'd4: return 16'h8000; // Most negative
			default: return '0;
		endcase
	endfunction

	// Returns {needed, src_reg, selector} biased toward read-after-write hazards
	function automatic logic [5:0] pick_source(input logic [31:0] r,
		input logic [chan_addr_width-1:0] own_dest);
		logic use_reg;
		logic [chan_addr_width-1:0] sel;
		use_reg = 1'b0;
		case (r[2:0])
			3'd0: begin
				use_reg = 1'b1;
				sel = r[6:3];
			end
			3'd1: sel = prev_dest;
			3'd2: sel = own_dest;
			default: sel = {2'b00, r[4:3]};
		endcase
		return {r[9:7] != 3'd0, use_reg, sel};
	endfunction

	task automatic stop_on_failure(input string detail);
		$display("** FAIL **");
		$display("%s", detail);
		$fatal(1, "Simulation stopped at cycle %0d", cycles);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		stop_on_failure($sformatf("** Error %s: expected %0h, actual %0h", name, expected, actual));
	endtask

	// Present one instruction, wait for the handshake and update the model
	task automatic transfer_instruction();
		logic [data_width-1:0] a, b, c;
		operation = in_count[op_width-1:0]; // Sequence tag
		in_valid = 1'b1;
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		a = expected_operand(src_a, src_a_reg, arg_a_needed);
		b = expected_operand(src_b, src_b_reg, arg_b_needed);
		c = expected_operand(src_c, src_c_reg, arg_c_needed);
		exp_op_mem[in_count] = operation;
		exp_dest_mem[in_count] = dest;
		exp_wr_mem[in_count] = writes_channel;
		exp_a_mem[in_count] = a;
		exp_b_mem[in_count] = b;
		exp_c_mem[in_count] = c;
		wb_val_mem[in_count] = a + b + c + data_width'(operation);
		if (writes_channel)
			model_ch[dest] = wb_val_mem[in_count];
		in_count++;
		#1;
		in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (out_count != in_count || wb_q.size() != 0)
			@(posedge clk);
		#1;
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		out_ready = 1'b1;
		rs_ready = seed ^ 32'h5a5a_0f0f;
		forever begin
			@(posedge clk);
			#1;
			if (ready_random) begin
				rs_ready = xorshift32(rs_ready);
				out_ready = rs_ready[1:0] != 2'b00;
			end else begin
				out_ready = 1'b1;
			end
		end
	end

	// Write-back emulation that writes one entry at a time in output order
	initial begin
		int idx;
		int wb_wait;
		logic [31:0] rs_wb;
		rs_wb = seed ^ 32'h3c3c_a5a5;
		wb_wait = 0;
		channel_write_enable = 1'b0;
		channel_write_addr = '0;
		channel_write_val = '0;
		forever begin
			@(posedge clk);
			#1;
			channel_write_enable = 1'b0;
			if (wb_wait > 0) begin
				wb_wait--;
			end else if (wb_q.size() > 0) begin
				idx = wb_q.pop_front();
				channel_write_enable = 1'b1;
				channel_write_addr = exp_dest_mem[idx];
				channel_write_val = wb_val_mem[idx];
				rs_wb = xorshift32(rs_wb);
				wb_wait = rs_wb % 7;
			end
		end
	end

	always @(posedge clk) begin
		prev_reset <= reset;
		if (reset) begin
			out_count <= 0;
			hs_delay <= '0;
			prev_hold <= 1'b0;
		end else begin
			hs_delay <= {hs_delay[1:0], in_valid & in_ready};
			prev_hold <= out_valid & ~out_ready;
			prev_result <= result_now;
			if (out_take) begin
				if (exp_wr_now)
					wb_q.push_back(out_count);
				out_count <= out_count + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			stop_on_failure($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
				cycles, out_count, n_instr));
	end

	assert property (@(posedge clk) (prev_reset && !reset) |-> (!out_valid && in_ready))
		else report_mismatch("reset_state", 64'h1, {$sampled(out_valid), $sampled(in_ready)});
	assert property (@(posedge clk) disable iff (reset) latency_check |-> out_valid == hs_delay[2])
		else report_mismatch("latency", $sampled(hs_delay[2]), $sampled(out_valid));
	assert property (@(posedge clk) disable iff (reset) out_take |-> out_count < in_count)
		else stop_on_failure("Result appeared with no accepted instruction left to match it");
	assert property (@(posedge clk) disable iff (reset) out_take |-> operation_out == exp_op_now)
		else report_mismatch("tag_order", $sampled(exp_op_now), $sampled(operation_out));
	assert property (@(posedge clk) disable iff (reset) out_take |-> dest_out == exp_dest_now)
		else report_mismatch("dest", $sampled(exp_dest_now), $sampled(dest_out));
	assert property (@(posedge clk) disable iff (reset)
		out_take |-> writes_channel_out == exp_wr_now)
		else report_mismatch("writes_channel", $sampled(exp_wr_now), $sampled(writes_channel_out));
	assert property (@(posedge clk) disable iff (reset) out_take |-> arg_a == exp_a_now)
		else report_mismatch("arg_a", $sampled(exp_a_now), $sampled(arg_a));
	assert property (@(posedge clk) disable iff (reset) out_take |-> arg_b == exp_b_now)
		else report_mismatch("arg_b", $sampled(exp_b_now), $sampled(arg_b));
	assert property (@(posedge clk) disable iff (reset) out_take |-> arg_c == exp_c_now)
		else report_mismatch("arg_c", $sampled(exp_c_now), $sampled(arg_c));
	assert property (@(posedge clk) disable iff (reset) prev_hold |-> out_valid)
		else stop_on_failure("out_valid dropped while the result was stalled by out_ready");
	assert property (@(posedge clk) disable iff (reset) prev_hold |-> result_now == prev_result)
		else report_mismatch("hold_stable", $sampled(prev_result), $sampled(result_now));

	initial begin
		logic [31:0] r;
		reset = 1'b1;
		in_valid = 1'b0;
		operation = '0;
		dest = '0;
		writes_channel = 1'b0;
		register_0 = '0;
		register_1 = '0;
		{src_a, src_a_reg, arg_a_needed} = '0;
		{src_b, src_b_reg, arg_b_needed} = '0;
		{src_c, src_c_reg, arg_c_needed} = '0;
		latency_check = 1'b0;
		ready_random = 1'b0;
		in_count = 0;
		cycles = 0;
		prev_dest = '0;
		rs_main = seed;
		for (int i = 0; i < n_channels; i++)
			model_ch[i] = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		latency_check = 1'b1;

		// Back-to-back hazard-free run over every source code
		for (int i = 0; i < n_latency; i++) begin
			r = next_random();
			dest = r[3:0];
			writes_channel = r[4];
			register_0 = r[31:16];
			register_1 = data_width'(next_random() >> 8);
			src_a.code = 4'(i % 16);
			src_b.code = 4'((i + 5) % 16);
			src_c.code = 4'((i + 11) % 16);
			{src_a_reg, src_b_reg, src_c_reg} = 3'b111;
			arg_a_needed = (i % 7) != 6;
			arg_b_needed = (i % 5) != 4;
			arg_c_needed = (i % 3) != 2;
			transfer_instruction();
		end
		wait_drain();
		latency_check = 1'b0;
		ready_random = 1'b1;

		// Channel hazards under random back-pressure
		for (int i = n_latency; i < n_instr; i++) begin
			r = next_random();
			while (r[2:0] == 3'd0 || wb_q.size() > 2) begin
				in_valid = 1'b0;
				@(posedge clk);
				#1;
				r = next_random();
			end
			dest = {2'b00, r[4:3]};
			writes_channel = r[6:5] != 2'b00;
			register_0 = r[31:16];
			register_1 = data_width'(next_random() >> 4);
			{arg_a_needed, src_a_reg, src_a} = pick_source(next_random(), dest);
			{arg_b_needed, src_b_reg, src_b} = pick_source(next_random(), dest);
			{arg_c_needed, src_c_reg, src_c} = pick_source(next_random(), dest);
			transfer_instruction();
			prev_dest = dest;
		end
		wait_drain();

		if (in_count == n_instr && out_count == n_instr) begin
			$display("** PASS **");
			$finish;
		end else begin
			stop_on_failure($sformatf("Run ended with %0d accepted and %0d results",
				in_count, out_count));
		end
	end
endmodule

/* op_fetch.f */
verilog/op_fetch_pkg.sv
verilog/channel_file.sv
verilog/pending_write_counter.sv
verilog/fetch_control.sv
verilog/operand_resolve.sv
verilog/fetch_substage.sv
verilog/skid_buffer.sv
verilog/op_fetch_stage.sv
bench/tb_op_fetch.sv

/* verilog/channel_file.sv */
`timescale 1ns/1ps

module channel_file import op_fetch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic write_enable,
	input logic [chan_addr_width-1:0] write_addr,
	input logic [data_width-1:0] write_val,
	input logic [chan_addr_width-1:0] read_addr_a,
	input logic [chan_addr_width-1:0] read_addr_b,
	input logic [chan_addr_width-1:0] read_addr_c,
	output logic [data_width-1:0] read_val_a,
	output logic [data_width-1:0] read_val_b,
	output logic [data_width-1:0] read_val_c
);
	logic [data_width-1:0] channels [n_channels];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_channels; i++)
				channels[i] <= '0;
		end else if (write_enable) begin
			channels[write_addr] <= write_val; // Write-back port only
		end
	end

	// One read port per substage
	assign read_val_a = channels[read_addr_a];
	assign read_val_b = channels[read_addr_b];
	assign read_val_c = channels[read_addr_c];
endmodule

/* verilog/fetch_control.sv */
`timescale 1ns/1ps

module fetch_control import op_fetch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic out_ready,
	input logic needs_stall,
	input logic resolved,
	output logic in_ready,
	output logic out_valid,
	output logic load_direct,
	output logic load_hold,
	output logic hold_release,
	output logic issue
);
	logic state;
	logic room;
	logic take;

	// Output register empty or being emptied this cycle
	assign room = ~out_valid | out_ready;

	assign in_ready = (state == state_idle) & room;
	assign take = in_valid & in_ready;

	assign load_direct = take & ~needs_stall;
	assign load_hold = take & needs_stall;
	assign hold_release = (state == state_hold) & resolved & room;

	// Instruction leaves the input side and its write becomes outstanding
	assign issue = load_direct | hold_release;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= state_idle;
			out_valid <= 1'b0;
		end else begin
			if (load_hold)
				state <= state_hold;
			else if (hold_release)
				state <= state_idle;

			if (issue)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0; // Taken downstream
		end
	end
endmodule

/* verilog/fetch_substage.sv */
`timescale 1ns/1ps

module fetch_substage import op_fetch_pkg::*; #(
	parameter int carry_width = 1
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	output logic out_valid,
	input logic out_ready,
	input logic [chan_addr_width-1:0] dest_in,
	input logic writes_channel_in,
	input logic [data_width-1:0] register_0_in,
	input logic [data_width-1:0] register_1_in,
	input logic [carry_width-1:0] carry_in,
	input operand_src_t src,
	input logic src_reg,
	input logic arg_needed,
	output logic [chan_addr_width-1:0] channel_read_addr,
	input logic [data_width-1:0] channel_read_val,
	input logic channel_write_enable,
	input logic [chan_addr_width-1:0] channel_write_addr,
	input logic [data_width-1:0] channel_write_val,
	output logic [chan_addr_width-1:0] dest_out,
	output logic writes_channel_out,
	output logic [data_width-1:0] register_0_out,
	output logic [data_width-1:0] register_1_out,
	output logic [carry_width-1:0] carry_out,
	output logic [data_width-1:0] fetched
);
	logic load_direct;
	logic load_hold;
	logic hold_release;
	logic issue;
	logic needs_stall;
	logic resolved;
	logic held;
	logic [pending_width-1:0] pending;
	logic [data_width-1:0] arg;
	logic [chan_addr_width-1:0] issue_addr;
	logic issue_write;

	logic [chan_addr_width-1:0] dest_held;
	logic writes_channel_held;
	logic [data_width-1:0] register_0_held;
	logic [data_width-1:0] register_1_held;
	logic [carry_width-1:0] carry_held;

	assign issue_addr = held ? dest_held : dest_in;
	assign issue_write = issue & (held ? writes_channel_held : writes_channel_in);

	fetch_control control (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .out_ready(out_ready),
		.needs_stall(needs_stall), .resolved(resolved),
		.in_ready(in_ready), .out_valid(out_valid),
		.load_direct(load_direct), .load_hold(load_hold),
		.hold_release(hold_release), .issue(issue)
	);

	pending_write_counter counter (
		.clk(clk), .reset(reset),
		.issue(issue_write), .issue_addr(issue_addr),
		.write_enable(channel_write_enable), .write_addr(channel_write_addr),
		.query_addr(channel_read_addr), .pending(pending)
	);

	operand_resolve resolver (
		.clk(clk), .reset(reset),
		.src_in(src), .src_reg_in(src_reg), .arg_needed_in(arg_needed),
		.register_0_in(register_0_in), .register_1_in(register_1_in),
		.load_hold(load_hold), .busy_hold(held), .pending(pending),
		.channel_read_val(channel_read_val),
		.write_enable(channel_write_enable), .write_addr(channel_write_addr),
		.write_val(channel_write_val),
		.query_addr(channel_read_addr), .needs_stall(needs_stall),
		.resolved(resolved), .arg(arg)
	);

	// Held copy occupied
	always_ff @(posedge clk) begin
		if (reset)
			held <= 1'b0;
		else if (load_hold)
			held <= 1'b1;
		else if (hold_release)
			held <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load_hold) begin
			dest_held <= dest_in;
			writes_channel_held <= writes_channel_in;
			register_0_held <= register_0_in;
			register_1_held <= register_1_in;
			carry_held <= carry_in;
		end
	end

	always_ff @(posedge clk) begin
		if (load_direct) begin
			dest_out <= dest_in;
			writes_channel_out <= writes_channel_in;
			register_0_out <= register_0_in;
			register_1_out <= register_1_in;
			carry_out <= carry_in;
		end else if (hold_release) begin
			dest_out <= dest_held;
			writes_channel_out <= writes_channel_held;
			register_0_out <= register_0_held;
			register_1_out <= register_1_held;
			carry_out <= carry_held;
		end
		if (load_direct | hold_release)
			fetched <= arg; // Direct value or the held capture
	end
endmodule

/* verilog/op_fetch_pkg.sv */
package op_fetch_pkg;
	localparam int data_width = 16;
	localparam int n_channels = 16;
	localparam int chan_addr_width = 4;
	localparam int pending_width = 4;
	localparam int op_width = 5;

	// Source codes when src_reg is set
	localparam logic [chan_addr_width-1:0] src_reg_0 = 4'd0;
	localparam logic [chan_addr_width-1:0] src_reg_1 = 4'd1;
	localparam logic [chan_addr_width-1:0] src_const_quarter = 4'd3;
	localparam logic [chan_addr_width-1:0] src_const_half = 4'd4;

	localparam logic [data_width-1:0] const_quarter = data_width'(1) << (data_width - 2);
	localparam logic [data_width-1:0] const_half = data_width'(1) << (data_width - 1); // Most negative

	localparam logic state_idle = 1'b0;
	localparam logic state_hold = 1'b1;

	// Carried payload between substages
	localparam int sel_width = chan_addr_width + 2; // Selector, src_reg, needed
	localparam int carry_1_width = op_width + 2 * sel_width;
	localparam int carry_2_width = op_width + data_width + sel_width;
	localparam int carry_3_width = op_width + 2 * data_width;
	localparam int result_width = op_width + chan_addr_width + 1 + 3 * data_width;

	// Same four bits, meaning set by the operand's src_reg bit
	typedef union packed {
		logic [chan_addr_width-1:0] channel;
		logic [chan_addr_width-1:0] code;
	} operand_src_t;
endpackage

/* verilog/op_fetch_stage.sv */
`timescale 1ns/1ps

module op_fetch_stage import op_fetch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic [op_width-1:0] operation,
	input logic [chan_addr_width-1:0] dest,
	input logic writes_channel,
	input logic [data_width-1:0] register_0,
	input logic [data_width-1:0] register_1,
	input operand_src_t src_a,
	input logic src_a_reg,
	input logic arg_a_needed,
	input operand_src_t src_b,
	input logic src_b_reg,
	input logic arg_b_needed,
	input operand_src_t src_c,
	input logic src_c_reg,
	input logic arg_c_needed,
	input logic channel_write_enable,
	input logic [chan_addr_width-1:0] channel_write_addr,
	input logic [data_width-1:0] channel_write_val,
	output logic out_valid,
	input logic out_ready,
	output logic [op_width-1:0] operation_out,
	output logic [chan_addr_width-1:0] dest_out,
	output logic writes_channel_out,
	output logic [data_width-1:0] arg_a,
	output logic [data_width-1:0] arg_b,
	output logic [data_width-1:0] arg_c
);
	logic valid_1, valid_2, valid_3;
	logic ready_2, ready_3, ready_skid;
	logic [chan_addr_width-1:0] read_addr_a, read_addr_b, read_addr_c;
	logic [data_width-1:0] read_val_a, read_val_b, read_val_c;
	logic [chan_addr_width-1:0] dest_1, dest_2, dest_3;
	logic writes_channel_1, writes_channel_2, writes_channel_3;
	logic [data_width-1:0] register_0_1, register_1_1, register_0_2, register_1_2;
	logic [data_width-1:0] fetched_a, fetched_b, fetched_c;

	logic [carry_1_width-1:0] carry_1_in, carry_1_out;
	logic [carry_2_width-1:0] carry_2_in, carry_2_out;
	logic [carry_3_width-1:0] carry_3_in, carry_3_out;
	logic [result_width-1:0] result_in, result_out;

	logic [op_width-1:0] op_1, op_2, op_3;
	operand_src_t src_b_1, src_c_1, src_c_2;
	logic src_b_reg_1, arg_b_needed_1, src_c_reg_1, arg_c_needed_1;
	logic src_c_reg_2, arg_c_needed_2;
	logic [data_width-1:0] arg_a_2, arg_a_3, arg_b_3;

	// Carry packing at each boundary
	assign carry_1_in = {operation, src_b, src_b_reg, arg_b_needed, src_c, src_c_reg, arg_c_needed};
	assign {op_1, src_b_1, src_b_reg_1, arg_b_needed_1, src_c_1, src_c_reg_1, arg_c_needed_1} =
		carry_1_out;
	assign carry_2_in = {op_1, fetched_a, src_c_1, src_c_reg_1, arg_c_needed_1};
	assign {op_2, arg_a_2, src_c_2, src_c_reg_2, arg_c_needed_2} = carry_2_out;
	assign carry_3_in = {op_2, arg_a_2, fetched_b};
	assign {op_3, arg_a_3, arg_b_3} = carry_3_out;

	assign result_in = {op_3, dest_3, writes_channel_3, arg_a_3, arg_b_3, fetched_c};
	assign {operation_out, dest_out, writes_channel_out, arg_a, arg_b, arg_c} = result_out;

	channel_file channels (
		.clk(clk), .reset(reset),
		.write_enable(channel_write_enable), .write_addr(channel_write_addr),
		.write_val(channel_write_val),
		.read_addr_a(read_addr_a), .read_addr_b(read_addr_b), .read_addr_c(read_addr_c),
		.read_val_a(read_val_a), .read_val_b(read_val_b), .read_val_c(read_val_c)
	);

	fetch_substage #(.carry_width(carry_1_width)) fetch_1 (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .out_valid(valid_1), .out_ready(ready_2),
		.dest_in(dest), .writes_channel_in(writes_channel),
		.register_0_in(register_0), .register_1_in(register_1), .carry_in(carry_1_in),
		.src(src_a), .src_reg(src_a_reg), .arg_needed(arg_a_needed),
		.channel_read_addr(read_addr_a), .channel_read_val(read_val_a),
		.channel_write_enable(channel_write_enable), .channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.dest_out(dest_1), .writes_channel_out(writes_channel_1),
		.register_0_out(register_0_1), .register_1_out(register_1_1),
		.carry_out(carry_1_out), .fetched(fetched_a)
	);

	fetch_substage #(.carry_width(carry_2_width)) fetch_2 (
		.clk(clk), .reset(reset),
		.in_valid(valid_1), .in_ready(ready_2), .out_valid(valid_2), .out_ready(ready_3),
		.dest_in(dest_1), .writes_channel_in(writes_channel_1),
		.register_0_in(register_0_1), .register_1_in(register_1_1), .carry_in(carry_2_in),
		.src(src_b_1), .src_reg(src_b_reg_1), .arg_needed(arg_b_needed_1),
		.channel_read_addr(read_addr_b), .channel_read_val(read_val_b),
		.channel_write_enable(channel_write_enable), .channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.dest_out(dest_2), .writes_channel_out(writes_channel_2),
		.register_0_out(register_0_2), .register_1_out(register_1_2),
		.carry_out(carry_2_out), .fetched(fetched_b)
	);

	// Registers are not carried past the last substage
	fetch_substage #(.carry_width(carry_3_width)) fetch_3 (
		.clk(clk), .reset(reset),
		.in_valid(valid_2), .in_ready(ready_3), .out_valid(valid_3), .out_ready(ready_skid),
		.dest_in(dest_2), .writes_channel_in(writes_channel_2),
		.register_0_in(register_0_2), .register_1_in(register_1_2), .carry_in(carry_3_in),
		.src(src_c_2), .src_reg(src_c_reg_2), .arg_needed(arg_c_needed_2),
		.channel_read_addr(read_addr_c), .channel_read_val(read_val_c),
		.channel_write_enable(channel_write_enable), .channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.dest_out(dest_3), .writes_channel_out(writes_channel_3),
		.register_0_out(), .register_1_out(),
		.carry_out(carry_3_out), .fetched(fetched_c)
	);

	skid_buffer #(.payload_width(result_width)) skid (
		.clk(clk), .reset(reset),
		.in_valid(valid_3), .in_ready(ready_skid),
		.out_valid(out_valid), .out_ready(out_ready),
		.payload_in(result_in), .payload_out(result_out)
	);
endmodule

/* verilog/operand_resolve.sv */
`timescale 1ns/1ps

module operand_resolve import op_fetch_pkg::*; (
	input logic clk,
	input logic reset,
	input operand_src_t src_in,
	input logic src_reg_in,
	input logic arg_needed_in,
	input logic [data_width-1:0] register_0_in,
	input logic [data_width-1:0] register_1_in,
	input logic load_hold,
	input logic busy_hold,
	input logic [pending_width-1:0] pending,
	input logic [data_width-1:0] channel_read_val,
	input logic write_enable,
	input logic [chan_addr_width-1:0] write_addr,
	input logic [data_width-1:0] write_val,
	output logic [chan_addr_width-1:0] query_addr,
	output logic needs_stall,
	output logic resolved,
	output logic [data_width-1:0] arg
);
	operand_src_t src_latched;
	logic [data_width-1:0] reg_value;
	logic [data_width-1:0] direct_value;
	logic [data_width-1:0] arg_held;
	logic capture_read;
	logic capture_forward;

	assign query_addr = busy_hold ? src_latched.channel : src_in.channel;
	assign needs_stall = arg_needed_in & ~src_reg_in & (pending != '0);

	always_comb begin
		case (src_in.code)
			src_reg_0: reg_value = register_0_in;
			src_reg_1: reg_value = register_1_in;
			src_const_quarter: reg_value = const_quarter;
			src_const_half: reg_value = const_half;
			default: reg_value = '0;
		endcase
	end

	assign direct_value = !arg_needed_in ? '0 : (src_reg_in ? reg_value : channel_read_val);
	assign arg = busy_hold ? arg_held : direct_value;

	// Last outstanding write lands now, take it straight off the write-back bus
	assign capture_read = busy_hold & ~resolved & (pending == '0);
	assign capture_forward = busy_hold & ~resolved & (pending == 1) & write_enable
		& (write_addr == src_latched.channel);

	always_ff @(posedge clk) begin
		if (load_hold)
			src_latched <= src_in;
		if (capture_read)
			arg_held <= channel_read_val;
		else if (capture_forward)
			arg_held <= write_val;
	end

	always_ff @(posedge clk) begin
		if (reset)
			resolved <= 1'b0;
		else
			resolved <= busy_hold & (resolved | capture_read | capture_forward);
	end
endmodule

/* verilog/pending_write_counter.sv */
`timescale 1ns/1ps

module pending_write_counter import op_fetch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic [chan_addr_width-1:0] issue_addr,
	input logic write_enable,
	input logic [chan_addr_width-1:0] write_addr,
	input logic [chan_addr_width-1:0] query_addr,
	output logic [pending_width-1:0] pending
);
	logic [pending_width-1:0] count [n_channels];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_channels; i++)
				count[i] <= '0;
		end else begin
			for (int i = 0; i < n_channels; i++) begin
				case ({issue && issue_addr == i, write_enable && write_addr == i})
					2'b10: begin
						count[i] <= count[i] + 1'b1;
					end
					2'b01: begin
						// Stray write-back leaves a zero count alone
						if (count[i] != '0)
							count[i] <= count[i] - 1'b1;
					end
					default: begin
						count[i] <= count[i]; // Issue and write-back cancel
					end
				endcase
			end
		end
	end

	assign pending = count[query_addr];
endmodule

/* verilog/skid_buffer.sv */
`timescale 1ns/1ps

module skid_buffer #(
	parameter int payload_width = 8
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	output logic out_valid,
	input logic out_ready,
	input logic [payload_width-1:0] payload_in,
	output logic [payload_width-1:0] payload_out
);
	logic full;
	logic [payload_width-1:0] spare;

	assign in_ready = ~full;
	assign out_valid = full | in_valid;
	assign payload_out = full ? spare : payload_in; // Pass-through when empty

	always_ff @(posedge clk) begin
		if (reset)
			full <= 1'b0;
		else if (full)
			full <= ~out_ready;
		else
			full <= in_valid & ~out_ready;
	end

	// Consumer stalled during a transfer
	always_ff @(posedge clk) begin
		if (~full & in_valid & ~out_ready)
			spare <= payload_in;
	end
endmodule
